// ==== verilog/doppler_pkg.sv ====
package doppler_pkg;

  // width of the modulator datapath, sawtooth samples share it
  localparam int PDM_BITS = 10;

  // one SPI frame, LED bits on write and pin states on readback
  typedef logic [15:0] spi_word_t;

  typedef logic [PDM_BITS-1:0] pdm_sample_t;  // sawtooth sample and pdm error

  // anode rows are driven low to light
  typedef logic [3:0] led_row_t;

  // cathode column enable, one-hot, the board wrapper turns it into a tristate
  typedef logic [3:0] led_col_t;

  // current LED, [3:2] column and [1:0] row
  typedef logic [3:0] scan_slot_t;

  // SPI lines after synchronization, all in the clk domain
  typedef struct packed {
    logic sck_rise;  // one cycle per rising serial clock
    logic cs_fall;   // frame start
    logic cs_rise;   // frame end
    logic mosi;      // data level, same delay as the pulses
  } spi_edges_t;

endpackage

// ==== verilog/spi_sync.sv ====
module spi_sync (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    sck,
  input  logic                    cs_n,
  input  logic                    mosi,
  output doppler_pkg::spi_edges_t edges
);

  // line order is {sck, cs_n, mosi}, idle bus has cs_n high
  localparam logic [2:0] LINES_IDLE = 3'b010;

  logic [2:0] meta_q;  // first stage, may go metastable
  logic [2:0] sync_q;
  logic [1:0] prev_q;  // edge reference for sck and cs_n only

  always_ff @(posedge clk) begin
    if (rst) begin
      meta_q <= LINES_IDLE;
      sync_q <= LINES_IDLE;
      prev_q <= LINES_IDLE[2:1];
    end else begin
      meta_q <= {sck, cs_n, mosi};
      sync_q <= meta_q;
      prev_q <= sync_q[2:1];
    end
  end

  // pulses and data leave through one register so they stay aligned
  always_ff @(posedge clk) begin
    if (rst) begin
      edges <= '0;
    end else begin
      edges.sck_rise <= sync_q[2] & ~prev_q[1];
      edges.cs_fall  <= ~sync_q[1] & prev_q[0];
      edges.cs_rise  <= sync_q[1] & ~prev_q[0];
      edges.mosi     <= sync_q[0];
    end
  end

endmodule

// ==== verilog/spi_shifter.sv ====
module spi_shifter (
  input  logic                    clk,
  input  logic                    rst,
  input  doppler_pkg::spi_edges_t edges,
  input  doppler_pkg::spi_word_t  pin_in,
  output logic                    miso,
  output doppler_pkg::spi_word_t  led_word
);

  localparam int WORD_BITS = $bits(doppler_pkg::spi_word_t);

  doppler_pkg::spi_word_t rx_q;  // receive shift, MSB first on the wire
  doppler_pkg::spi_word_t tx_q;  // pin snapshot, shifted out MSB first

  // controller samples on the rising serial clock, so the next bit
  // must already sit at the top of tx_q
  assign miso = tx_q[WORD_BITS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_q     <= '0;
      tx_q     <= '0;
      led_word <= '0;
    end else if (edges.cs_rise) begin
      led_word <= rx_q;  // a short frame commits whatever has shifted in
    end else if (edges.cs_fall) begin
      tx_q <= pin_in;  // capture pins at frame start
    end else if (edges.sck_rise) begin
      rx_q <= {rx_q[WORD_BITS-2:0], edges.mosi};
      tx_q <= {tx_q[WORD_BITS-2:0], 1'b1};  // ones fill in behind the data
    end
  end

endmodule

// ==== verilog/led_matrix_scan.sv ====
module led_matrix_scan #(
  parameter int SCAN_DIV_BITS = 5
) (
  input  logic                   clk,
  input  logic                   rst,
  input  doppler_pkg::spi_word_t led_word,
  input  logic                   pdm_bit,
  output doppler_pkg::led_row_t  aled,
  output doppler_pkg::led_col_t  kled_en
);

  logic [SCAN_DIV_BITS-1:0] div_cnt;
  logic                     slot_step;  // clock enable for the slot counter
  doppler_pkg::scan_slot_t  slot;
  logic                     slot_lit;

  assign slot_step = &div_cnt;
  assign slot_lit  = led_word[slot] & pdm_bit;

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // one LED per slot, 16 slots per pass
  always_ff @(posedge clk) begin
    if (rst) begin
      slot <= '0;
    end else if (slot_step) begin
      slot <= slot + 1'b1;
    end
  end

  // row select is active low, the column is enabled only for a lit LED
  always_ff @(posedge clk) begin
    if (rst) begin
      aled    <= '1;  // no row driven
      kled_en <= '0;
    end else begin
      aled <= ~(doppler_pkg::led_row_t'(1) << slot[1:0]);
      if (slot_lit) begin
        kled_en <= doppler_pkg::led_col_t'(1) << slot[3:2];
      end else begin
        kled_en <= '0;
      end
    end
  end

endmodule

// ==== verilog/saw_gen.sv ====
module saw_gen #(
  parameter int SAW_DIV = 100000
) (
  input  logic                     clk,
  input  logic                     rst,
  output doppler_pkg::pdm_sample_t sample
);

  localparam int CNT_W = (SAW_DIV > 0) ? $clog2(SAW_DIV + 1) : 1;

  logic [CNT_W-1:0]         div_cnt;
  doppler_pkg::pdm_sample_t amp;  // falls from full scale to zero

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
      amp     <= '1;
    end else if (div_cnt == CNT_W'(SAW_DIV)) begin
      div_cnt <= '0;
      amp     <= amp - 1'b1;  // wraps from zero back to all ones
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sample <= '1;
    end else begin
      sample <= amp;
    end
  end

endmodule

// ==== verilog/pdm_mod.sv ====
module pdm_mod (
  input  logic                     clk,
  input  logic                     rst,
  input  doppler_pkg::pdm_sample_t din,
  output logic                     dout
);

  localparam doppler_pkg::pdm_sample_t SAMPLE_MAX = '1;

  doppler_pkg::pdm_sample_t din_q;
  doppler_pkg::pdm_sample_t error;
  doppler_pkg::pdm_sample_t err_hi;  // next error if a one goes out
  doppler_pkg::pdm_sample_t err_lo;  // next error if a zero goes out

  // both candidates are ready a cycle ahead, the decision only picks one
  always_ff @(posedge clk) begin
    if (rst) begin
      din_q  <= '0;
      err_hi <= '0;
      err_lo <= '0;
    end else begin
      din_q  <= din;
      err_hi <= error + SAMPLE_MAX - din_q;
      err_lo <= error - din_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dout  <= 1'b0;
      error <= '0;
    end else if (din_q >= error) begin
      dout  <= 1'b1;
      error <= err_hi;
    end else begin
      dout  <= 1'b0;
      error <= err_lo;
    end
  end

endmodule

// ==== verilog/doppler_top.sv ====
module doppler_top #(
  parameter int SCAN_DIV_BITS = 5,
  parameter int SAW_DIV       = 100000
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   spi_sck,
  input  logic                   spi_cs_n,
  input  logic                   spi_mosi,
  input  doppler_pkg::spi_word_t pin_in,
  output logic                   spi_miso,
  output doppler_pkg::led_row_t  aled,
  output doppler_pkg::led_col_t  kled_en
);

  doppler_pkg::spi_edges_t  spi_edges;
  doppler_pkg::spi_word_t   led_word;
  doppler_pkg::pdm_sample_t saw_sample;
  logic                     pdm_bit;  // dims the matrix through the column enable

  spi_sync u_spi_sync (
    .clk   (clk),
    .rst   (rst),
    .sck   (spi_sck),
    .cs_n  (spi_cs_n),
    .mosi  (spi_mosi),
    .edges (spi_edges)
  );

  spi_shifter u_spi_shifter (
    .clk      (clk),
    .rst      (rst),
    .edges    (spi_edges),
    .pin_in   (pin_in),
    .miso     (spi_miso),
    .led_word (led_word)
  );

  saw_gen #(.SAW_DIV(SAW_DIV)) u_saw_gen (
    .clk    (clk),
    .rst    (rst),
    .sample (saw_sample)
  );

  pdm_mod u_pdm_mod (
    .clk  (clk),
    .rst  (rst),
    .din  (saw_sample),
    .dout (pdm_bit)
  );

  led_matrix_scan #(.SCAN_DIV_BITS(SCAN_DIV_BITS)) u_led_matrix_scan (
    .clk      (clk),
    .rst      (rst),
    .led_word (led_word),
    .pdm_bit  (pdm_bit),
    .aled     (aled),
    .kled_en  (kled_en)
  );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock #(
  parameter int HALF_NS    = 4,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;  // released on an edge like any other input
  end

  always #(HALF_NS) clk = ~clk;

endmodule

// ==== bench/doppler_tb.sv ====
module doppler_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SCAN_DIV_BITS = 5;
  localparam int SAW_DIV       = 3;
  localparam int NUM_FRAMES    = 40;
  localparam int MAX_HALF      = 9;  // longest serial clock half period in clocks
  localparam int CLK_NS        = 8;
  localparam int SAW_PERIOD    = (SAW_DIV + 1) << doppler_pkg::PDM_BITS;
  localparam int QUARTER       = SAW_PERIOD / 4;
  localparam int WATCHDOG_NS   = NUM_FRAMES * 40 * 2 * MAX_HALF * CLK_NS
                               + SAW_PERIOD * CLK_NS + 20000;
  localparam doppler_pkg::pdm_sample_t PDM_MAX = '1;

  logic                   clk;
  logic                   rst;
  logic                   spi_sck;
  logic                   spi_cs_n;
  logic                   spi_mosi;
  doppler_pkg::spi_word_t pin_in;
  logic                   spi_miso;
  doppler_pkg::led_row_t  aled;
  doppler_pkg::led_col_t  kled_en;

  int mismatch_cnt = 0;
  int other_cnt    = 0;
  int frames_done  = 0;

  // reference model state stepped on every rising edge
  bit                       m_valid = 1'b0;
  int                       m_steps;  // clock edges since reset
  int                       m_cnt;
  doppler_pkg::pdm_sample_t m_amp;
  doppler_pkg::pdm_sample_t m_sample;
  doppler_pkg::pdm_sample_t m_din_q;
  doppler_pkg::pdm_sample_t m_hi;
  doppler_pkg::pdm_sample_t m_lo;
  doppler_pkg::pdm_sample_t m_err;
  logic                     m_dout;
  doppler_pkg::spi_word_t   m_rx;
  doppler_pkg::spi_word_t   m_led;
  logic                     m_sck_prev;
  logic                     m_cs_prev;
  logic [2:0]               ev_sck;  // pin events waiting to land
  logic [2:0]               ev_cs;
  logic [2:0]               ev_mosi;
  doppler_pkg::led_row_t    exp_aled;
  doppler_pkg::led_col_t    exp_kled;
  int                       quarter_ones[4];
  bit                       density_done = 1'b0;

  doppler_pkg::spi_word_t   exp_rx = '0;  // receive word as the stimulus sees it

  tb_clock #(.HALF_NS(CLK_NS / 2), .RST_CYCLES(4)) u_clock (
    .clk (clk),
    .rst (rst)
  );

  doppler_top #(.SCAN_DIV_BITS(SCAN_DIV_BITS), .SAW_DIV(SAW_DIV)) DUT (
    .clk      (clk),
    .rst      (rst),
    .spi_sck  (spi_sck),
    .spi_cs_n (spi_cs_n),
    .spi_mosi (spi_mosi),
    .pin_in   (pin_in),
    .spi_miso (spi_miso),
    .aled     (aled),
    .kled_en  (kled_en)
  );

  task automatic compare_word(input doppler_pkg::spi_word_t got,
                              input doppler_pkg::spi_word_t exp, input string what);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_row(input doppler_pkg::led_row_t got,
                             input doppler_pkg::led_row_t exp, input string what);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_col(input doppler_pkg::led_col_t got,
                             input doppler_pkg::led_col_t exp, input string what);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    other_cnt++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  always @(posedge clk) begin : model_step
    doppler_pkg::scan_slot_t  slot;
    doppler_pkg::pdm_sample_t t_hi;
    doppler_pkg::pdm_sample_t t_lo;
    if (rst) begin
      m_steps = 0;
      m_cnt = 0;
      m_amp = '1;
      m_sample = '1;
      m_din_q = '0;
      m_hi = '0;
      m_lo = '0;
      m_err = '0;
      m_dout = 1'b0;
      m_rx = '0;
      m_led = '0;
      m_sck_prev = 1'b0;
      m_cs_prev = 1'b1;  // idle bus
      ev_sck = '0;
      ev_cs = '0;
      ev_mosi = '0;
      exp_aled = '1;
      exp_kled = '0;
    end else begin
      // outputs come from the state before this edge
      slot = doppler_pkg::scan_slot_t'(m_steps >> SCAN_DIV_BITS);
      exp_aled = ~(doppler_pkg::led_row_t'(1) << slot[1:0]);
      exp_kled = (m_led[slot] && m_dout) ? (doppler_pkg::led_col_t'(1) << slot[3:2]) : '0;
      if (ev_cs[2]) begin
        m_led = m_rx;  // frame end commits the receive word
      end else if (ev_sck[2]) begin
        m_rx = {m_rx[14:0], ev_mosi[2]};
      end
      ev_sck = {ev_sck[1:0], spi_sck & ~m_sck_prev};
      ev_cs = {ev_cs[1:0], spi_cs_n & ~m_cs_prev};
      ev_mosi = {ev_mosi[1:0], spi_mosi};
      m_sck_prev = spi_sck;
      m_cs_prev = spi_cs_n;
      t_hi = m_err + PDM_MAX - m_din_q;
      t_lo = m_err - m_din_q;
      m_dout = (m_din_q >= m_err);
      m_err = m_dout ? m_hi : m_lo;
      m_hi = t_hi;
      m_lo = t_lo;
      m_din_q = m_sample;
      m_sample = m_amp;
      if (m_cnt == SAW_DIV) begin
        m_cnt = 0;
        m_amp = m_amp - 1'b1;
      end else begin
        m_cnt++;
      end
      m_steps++;
      if (m_steps <= SAW_PERIOD) begin
        if (DUT.pdm_bit) quarter_ones[(m_steps - 1) / QUARTER]++;
        if (m_steps == SAW_PERIOD) begin
          if (!(quarter_ones[0] > quarter_ones[1] && quarter_ones[1] > quarter_ones[2] &&
                quarter_ones[2] > quarter_ones[3])) begin
            report_error($sformatf("pdm density does not fall with the sawtooth: %0d %0d %0d %0d",
                                   quarter_ones[0], quarter_ones[1],
                                   quarter_ones[2], quarter_ones[3]));
          end
          density_done = 1'b1;
        end
      end
    end
    m_valid = 1'b1;
  end

  // matrix drive against the model in every cycle
  always @(negedge clk) begin
    if (m_valid) begin
      compare_row(aled, exp_aled, "aled");
      compare_col(kled_en, exp_kled, "kled_en");
    end
  end

  // one SPI frame in mode 0 that may be cut short after nbits
  task automatic run_frame(input doppler_pkg::spi_word_t data,
                           input doppler_pkg::spi_word_t pins, input int nbits,
                           input int half);
    doppler_pkg::spi_word_t got;
    doppler_pkg::spi_word_t mask;
    got = '0;
    mask = ~(16'hffff >> nbits);
    spi_cs_n <= 1'b0;
    spi_mosi <= data[15];
    repeat (half + 1) @(posedge clk);  // lets the pin snapshot reach miso
    for (int k = 0; k < nbits; k++) begin
      @(negedge clk);
      got[15-k] = spi_miso;  // sampled just before the rising serial clock
      @(posedge clk);
      spi_sck <= 1'b1;
      exp_rx = {exp_rx[14:0], data[15-k]};
      repeat (half) @(posedge clk);
      spi_sck <= 1'b0;
      if (k < 15) spi_mosi <= data[14-k];
      repeat (half - 1) @(posedge clk);
    end
    @(posedge clk);
    spi_cs_n <= 1'b1;
    compare_word(got & mask, pins & mask, "miso readback");
    repeat (6) @(posedge clk);  // frame end pulse and commit
    @(negedge clk);
    compare_word(DUT.u_spi_shifter.led_word, exp_rx, "led_word");
    @(posedge clk);
    frames_done++;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Test failures found");
    $finish;
  end

  initial begin
    doppler_pkg::spi_word_t data;
    doppler_pkg::spi_word_t pins;
    int half;
    int nbits;
    int gap;
    spi_sck = 1'b0;
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    pin_in = '0;
    void'($urandom(32'h80be_7185));
    while (rst !== 1'b0) @(posedge clk);
    repeat (8) begin
      @(negedge clk);
      compare_bit(spi_miso, 1'b0, "spi_miso after reset");
    end
    @(posedge clk);
    for (int f = 0; f < NUM_FRAMES; f++) begin
      data = doppler_pkg::spi_word_t'($urandom);
      pins = doppler_pkg::spi_word_t'($urandom);
      half = $urandom_range(MAX_HALF, 4);
      nbits = ($urandom_range(4, 0) == 0) ? $urandom_range(15, 1) : 16;
      gap = $urandom_range(20, 4);
      repeat (gap) @(posedge clk);
      pin_in <= pins;  // only while chip select is high
      repeat (2) @(posedge clk);
      run_frame(data, pins, nbits, half);
    end
    while (!density_done) @(posedge clk);  // one full saw period has to pass
    repeat (4) @(posedge clk);
    $display("frames %0d, mismatches %0d, other errors %0d",
             frames_done, mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== doppler_io.f ====
verilog/doppler_pkg.sv
verilog/spi_sync.sv
verilog/spi_shifter.sv
verilog/led_matrix_scan.sv
verilog/saw_gen.sv
verilog/pdm_mod.sv
verilog/doppler_top.sv
bench/tb_clock.sv
bench/doppler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the doppler_io testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf build
verilator --binary --timing -j 0 \
  --top-module doppler_tb \
  --Mdir build -o doppler_sim \
  -f doppler_io.f

./build/doppler_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation passed"
exit 0
